//--- i2c_pkg.sv
package i2c_pkg;

    // CLK cycles per quarter of an SCL bit
    localparam int SCL_QUARTER = 1;

    // fixed upper nibble of every 24Cxx control byte
    localparam logic [3:0] DEV_CODE = 4'b1010;

    typedef enum logic [1:0] {
        I2C_START = 2'd0,
        I2C_STOP  = 2'd1,
        I2C_WRITE = 2'd2,
        I2C_READ  = 2'd3
    } i2c_op_t;

    typedef struct packed {
        i2c_op_t    op;
        logic [7:0] tx_byte;
        logic       master_ack;   // 1 pulls SDA low in the ack slot of a READ
    } i2c_cmd_t;

    typedef struct packed {
        logic [3:0] dev_code;
        logic [2:0] block;        // word address bits 10:8
        logic       rw;           // 1 read
    } i2c_ctrl_byte_t;

    // one byte on the wire, plain data or a control byte
    typedef union packed {
        logic [7:0]     raw;
        i2c_ctrl_byte_t ctrl;
    } i2c_byte_u;

endpackage

//--- eeprom_pkg.sv
package eeprom_pkg;

    localparam int AXI_AW = 4;
    localparam int AXI_DW = 32;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // register byte offsets
    localparam logic [AXI_AW-1:0] REG_ADDR   = 4'h0;
    localparam logic [AXI_AW-1:0] REG_WDATA  = 4'h4;
    localparam logic [AXI_AW-1:0] REG_CTRL   = 4'h8;
    localparam logic [AXI_AW-1:0] REG_STATUS = 4'hC;

    // CTRL bit positions, read wins when both are set
    localparam int CTRL_WRITE = 0;
    localparam int CTRL_READ  = 1;

    // request handed to the sequencer with start
    typedef struct packed {
        logic        rw;          // 1 random read, 0 byte write
        logic [10:0] addr;
        logic [7:0]  wdata;
    } eeprom_req_t;

    // result, done is a single cycle pulse
    typedef struct packed {
        logic       done;
        logic       nack;
        logic [7:0] rdata;
    } eeprom_rsp_t;

endpackage

//--- axil_eeprom_regs.sv
`timescale 1ns/100ps

module axil_eeprom_regs import eeprom_pkg::*;
(
    input  logic                CLK,
    input  logic                RESET,
    input  logic [AXI_AW-1:0]   s_awaddr,
    input  logic                s_awvalid,
    output logic                s_awready,
    input  logic [AXI_DW-1:0]   s_wdata,
    input  logic [AXI_DW/8-1:0] s_wstrb,
    input  logic                s_wvalid,
    output logic                s_wready,
    output logic [1:0]          s_bresp,
    output logic                s_bvalid,
    input  logic                s_bready,
    input  logic [AXI_AW-1:0]   s_araddr,
    input  logic                s_arvalid,
    output logic                s_arready,
    output logic [AXI_DW-1:0]   s_rdata,
    output logic [1:0]          s_rresp,
    output logic                s_rvalid,
    input  logic                s_rready,
    input  logic                busy,
    input  eeprom_rsp_t         rsp,
    output logic                start,
    output eeprom_req_t         req
);

    logic [AXI_AW-1:0]   aw_q;
    logic [AXI_DW-1:0]   wd_q;
    logic [AXI_DW/8-1:0] ws_q;
    logic                aw_held;
    logic                w_held;
    logic                wr_commit;
    logic                ctrl_fire;
    logic                busy_live;   // includes a start not yet seen by the sequencer
    logic [10:0]         addr_q;
    logic [7:0]          wdata_q;
    logic                done_q;
    logic                nack_q;
    logic [7:0]          rdata_q;
    logic [AXI_DW-1:0]   status_word;
    logic [AXI_DW-1:0]   rd_word;
    logic [1:0]          rd_resp;

    assign busy_live   = busy | start;
    assign wr_commit   = aw_held && w_held && !s_bvalid;
    assign ctrl_fire   = wr_commit && (aw_q == REG_CTRL) && ws_q[0] && !busy_live &&
                         (wd_q[CTRL_WRITE] || wd_q[CTRL_READ]);
    assign status_word = {16'd0, rdata_q, 5'd0, nack_q, done_q, busy_live};

    always_comb
    begin
        rd_resp = RESP_OKAY;
        case (s_araddr)
            REG_ADDR:   rd_word = {21'd0, addr_q};
            REG_WDATA:  rd_word = {24'd0, wdata_q};
            REG_CTRL:   rd_word = '0;            // self clearing
            REG_STATUS: rd_word = status_word;
            default:
            begin
                rd_word = '0;
                rd_resp = RESP_SLVERR;
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            s_awready <= 1'b0;
            s_wready  <= 1'b0;
            s_bvalid  <= 1'b0;
            s_bresp   <= RESP_OKAY;
            s_arready <= 1'b0;
            s_rvalid  <= 1'b0;
            s_rdata   <= '0;
            s_rresp   <= RESP_OKAY;
            aw_held   <= 1'b0;
            w_held    <= 1'b0;
            start     <= 1'b0;
            addr_q    <= '0;
            wdata_q   <= '0;
            done_q    <= 1'b0;
            nack_q    <= 1'b0;
            rdata_q   <= '0;
        end
        else
        begin
            start     <= ctrl_fire;
            s_awready <= !s_awready && s_awvalid && !aw_held;
            s_wready  <= !s_wready && s_wvalid && !w_held;
            if (s_awready && s_awvalid)
                aw_held <= 1'b1;
            if (s_wready && s_wvalid)
                w_held <= 1'b1;

            if (wr_commit)
            begin
                aw_held  <= 1'b0;
                w_held   <= 1'b0;
                s_bvalid <= 1'b1;
                s_bresp  <= RESP_OKAY;
                case (aw_q)
                    REG_ADDR:
                    begin
                        if (ws_q[0])
                            addr_q[7:0] <= wd_q[7:0];
                        if (ws_q[1])
                            addr_q[10:8] <= wd_q[10:8];
                    end
                    REG_WDATA:
                        if (ws_q[0])
                            wdata_q <= wd_q[7:0];
                    REG_CTRL:
                        if (ctrl_fire)
                            done_q <= 1'b0;
                    REG_STATUS: ;                // read only
                    default:
                        s_bresp <= RESP_SLVERR;
                endcase
            end
            else if (s_bvalid && s_bready)
                s_bvalid <= 1'b0;

            if (rsp.done)
            begin
                done_q  <= 1'b1;
                nack_q  <= rsp.nack;
                rdata_q <= rsp.rdata;
            end

            s_arready <= !s_arready && s_arvalid && !s_rvalid;
            if (s_arready && s_arvalid)
            begin
                s_rvalid <= 1'b1;
                s_rdata  <= rd_word;
                s_rresp  <= rd_resp;
            end
            else if (s_rvalid && s_rready)
                s_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (s_awready && s_awvalid)
            aw_q <= s_awaddr;
        if (s_wready && s_wvalid)
        begin
            wd_q <= s_wdata;
            ws_q <= s_wstrb;
        end
        if (ctrl_fire)
            req <= '{rw: wd_q[CTRL_READ], addr: addr_q, wdata: wdata_q};
    end

endmodule

//--- eeprom_txn_seq.sv
`timescale 1ns/100ps

module eeprom_txn_seq import eeprom_pkg::*, i2c_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        start,
    input  eeprom_req_t req,
    output logic        busy,
    output logic        cmd_valid,
    input  logic        cmd_ready,
    output i2c_cmd_t    cmd,
    input  logic        op_done,
    input  logic [7:0]  rx_byte,
    input  logic        slave_ack,
    output eeprom_rsp_t rsp
);

    // one state per bus phase of the transaction
    typedef enum logic [9:0] {
        S_IDLE     = 10'b00_0000_0001,
        S_WR_START = 10'b00_0000_0010,
        S_CTRL_WR  = 10'b00_0000_0100,
        S_ADDR_WR  = 10'b00_0000_1000,
        S_DATA_WR  = 10'b00_0001_0000,
        S_RD_START = 10'b00_0010_0000,
        S_CTRL_RD  = 10'b00_0100_0000,
        S_DATA_RD  = 10'b00_1000_0000,
        S_STOP     = 10'b01_0000_0000,
        S_ACKN     = 10'b10_0000_0000
    } state_t;

    state_t      state;
    state_t      next_state;
    logic        issued;       // command taken, waiting for op_done
    logic        wrote_byte;
    logic        nack_q;
    logic [7:0]  rdata_q;
    eeprom_req_t req_q;
    i2c_byte_u   tx;

    assign busy      = (state != S_IDLE);
    assign cmd_valid = !issued && (state != S_IDLE) && (state != S_ACKN);
    assign rsp       = '{done: (state == S_ACKN), nack: nack_q, rdata: rdata_q};

    always_comb
    begin
        tx.raw         = 8'h00;
        cmd.op         = I2C_WRITE;
        cmd.master_ack = 1'b0;    // single byte read ends with NACK
        case (state)
            S_WR_START, S_RD_START:
                cmd.op = I2C_START;
            S_CTRL_WR:
                tx.ctrl = '{dev_code: DEV_CODE, block: req_q.addr[10:8], rw: 1'b0};
            S_ADDR_WR:
                tx.raw = req_q.addr[7:0];
            S_DATA_WR:
                tx.raw = req_q.wdata;
            S_CTRL_RD:
                tx.ctrl = '{dev_code: DEV_CODE, block: req_q.addr[10:8], rw: 1'b1};
            S_DATA_RD:
                cmd.op = I2C_READ;
            S_STOP:
                cmd.op = I2C_STOP;
            default: ;
        endcase
        cmd.tx_byte = tx.raw;
    end

    always_comb
    begin
        wrote_byte = (state == S_CTRL_WR) || (state == S_ADDR_WR) ||
                     (state == S_DATA_WR) || (state == S_CTRL_RD);
        case (state)
            S_WR_START: next_state = S_CTRL_WR;
            S_CTRL_WR:  next_state = S_ADDR_WR;
            S_ADDR_WR:  next_state = req_q.rw ? S_RD_START : S_DATA_WR;
            S_DATA_WR:  next_state = S_STOP;
            S_RD_START: next_state = S_CTRL_RD;
            S_CTRL_RD:  next_state = S_DATA_RD;
            S_DATA_RD:  next_state = S_STOP;
            S_STOP:     next_state = S_ACKN;
            default:    next_state = S_IDLE;
        endcase
        if (wrote_byte && !slave_ack)
            next_state = S_STOP;  // abort straight to stop
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state  <= S_IDLE;
            issued <= 1'b0;
            nack_q <= 1'b0;
        end
        else
        begin
            if (cmd_valid && cmd_ready)
                issued <= 1'b1;
            case (state)
                S_IDLE:
                    if (start)
                    begin
                        nack_q <= 1'b0;
                        state  <= S_WR_START;
                    end
                S_ACKN:
                    state <= S_IDLE;
                default:
                    if (op_done)
                    begin
                        issued <= 1'b0;
                        state  <= next_state;
                        if (wrote_byte && !slave_ack)
                            nack_q <= 1'b1;
                    end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == S_IDLE && start)
            req_q <= req;
        if (state == S_DATA_RD && op_done)
            rdata_q <= rx_byte;
    end

endmodule

//--- i2c_bit_engine.sv
`timescale 1ns/100ps

module i2c_bit_engine import i2c_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       cmd_valid,
    output logic       cmd_ready,
    input  i2c_cmd_t   cmd,
    output logic       op_done,
    output logic [7:0] rx_byte,
    output logic       slave_ack,
    output logic       scl_low,
    output logic       sda_low,
    input  logic       sda_in
);

    localparam int QW = (SCL_QUARTER > 1) ? $clog2(SCL_QUARTER) : 1;

    i2c_op_t       op;
    logic          active;       // transfer in progress
    logic [QW-1:0] qcnt;
    logic [1:0]    phase;        // 0 and 3 SCL low, 1 and 2 SCL high
    logic [3:0]    bit_cnt;      // 8 is the ack slot
    logic [8:0]    tx_bits;      // line levels, MSB first
    logic          tick;
    logic          byte_op;
    logic          first_level;

    // {scl_low, sda_low} for one quarter of the given operation
    function automatic logic [1:0] line_drive(i2c_op_t o, logic [1:0] ph, logic level);
        logic scl_l;
        logic sda_l;
        scl_l = (ph == 2'd0) || (ph == 2'd3 && o != I2C_STOP);   // a stop leaves SCL high
        case (o)
            I2C_START: sda_l = ph[1];     // SDA falls in the middle of SCL high
            I2C_STOP:  sda_l = !ph[1];    // SDA rises in the middle of SCL high
            default:   sda_l = !level;
        endcase
        return {scl_l, sda_l};
    endfunction

    assign cmd_ready   = !active;
    assign tick        = (qcnt == QW'(SCL_QUARTER - 1));
    assign byte_op     = (op == I2C_WRITE) || (op == I2C_READ);
    assign first_level = (cmd.op == I2C_READ) ? 1'b1 : cmd.tx_byte[7];

    // START always begins with SCL low, so a start from a free bus
    // and a repeated start share the same four quarters
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active  <= 1'b0;
            op_done <= 1'b0;
            scl_low <= 1'b0;
            sda_low <= 1'b0;
            qcnt    <= '0;
            phase   <= 2'd0;
            bit_cnt <= 4'd0;
        end
        else
        begin
            op_done <= 1'b0;
            if (!active)
            begin
                qcnt <= '0;
                if (cmd_valid)
                begin
                    active  <= 1'b1;
                    phase   <= 2'd0;
                    bit_cnt <= 4'd0;
                    {scl_low, sda_low} <= line_drive(cmd.op, 2'd0, first_level);
                end
            end
            else if (!tick)
                qcnt <= qcnt + 1'b1;
            else
            begin
                qcnt <= '0;
                if (phase != 2'd3)
                begin
                    phase <= phase + 2'd1;
                    {scl_low, sda_low} <= line_drive(op, phase + 2'd1, tx_bits[8]);
                end
                else if (byte_op && bit_cnt != 4'd8)
                begin
                    phase   <= 2'd0;
                    bit_cnt <= bit_cnt + 4'd1;
                    {scl_low, sda_low} <= line_drive(op, 2'd0, tx_bits[7]);
                end
                else
                begin
                    active  <= 1'b0;       // lines hold their last level
                    op_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!active && cmd_valid)
        begin
            op <= cmd.op;
            if (cmd.op == I2C_READ)
                tx_bits <= {8'hff, !cmd.master_ack};
            else
                tx_bits <= {cmd.tx_byte, 1'b1};  // release SDA for the slave ack
        end
        else if (active && tick && phase == 2'd3)
            tx_bits <= {tx_bits[7:0], 1'b1};

        // sample at the end of the first high quarter
        if (active && tick && phase == 2'd1 && byte_op)
        begin
            if (bit_cnt == 4'd8)
                slave_ack <= !sda_in;
            else
                rx_byte <= {rx_byte[6:0], sda_in};
        end
    end

endmodule

//--- eeprom_ctrl_top.sv
`timescale 1ns/100ps

module eeprom_ctrl_top import eeprom_pkg::*, i2c_pkg::*;
(
    input  logic                CLK,
    input  logic                RESET,
    input  logic [AXI_AW-1:0]   s_awaddr,
    input  logic                s_awvalid,
    output logic                s_awready,
    input  logic [AXI_DW-1:0]   s_wdata,
    input  logic [AXI_DW/8-1:0] s_wstrb,
    input  logic                s_wvalid,
    output logic                s_wready,
    output logic [1:0]          s_bresp,
    output logic                s_bvalid,
    input  logic                s_bready,
    input  logic [AXI_AW-1:0]   s_araddr,
    input  logic                s_arvalid,
    output logic                s_arready,
    output logic [AXI_DW-1:0]   s_rdata,
    output logic [1:0]          s_rresp,
    output logic                s_rvalid,
    input  logic                s_rready,
    input  logic                sda_in,
    output logic                scl_low,    // open drain, 1 pulls SCL low
    output logic                sda_low
);

    logic        start;
    logic        busy;
    eeprom_req_t req;
    eeprom_rsp_t rsp;
    logic        cmd_valid;
    logic        cmd_ready;
    i2c_cmd_t    cmd;
    logic        op_done;
    logic [7:0]  rx_byte;
    logic        slave_ack;

    axil_eeprom_regs u_regs (.*);

    eeprom_txn_seq u_seq (.*);

    i2c_bit_engine u_engine (.*);

endmodule

//--- eeprom_model.sv
`timescale 1ns/100ps

module eeprom_model import i2c_pkg::*;
(
    input  logic scl,
    input  logic sda,
    input  logic nack_all,
    output logic sda_low
);

    logic [7:0]  mem [0:2047];
    logic [10:0] addr;
    logic [7:0]  shift;
    logic [7:0]  dout;
    logic        active;      // addressed since the last start
    logic        reading;     // model owns SDA for the data bits
    logic        rd_next;     // control byte asked for a read
    logic        skip_fall;   // falling SCL that closes a start
    int          bit_idx;     // 8 is the ack slot
    int          byte_idx;
    i2c_byte_u   rx;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hff;
        addr      = '0;
        sda_low   = 1'b0;
        active    = 1'b0;
        reading   = 1'b0;
        rd_next   = 1'b0;
        skip_fall = 1'b0;
    end

    task automatic take_byte();
        rx.raw = shift;
        if (nack_all || (byte_idx == 0 && rx.ctrl.dev_code != DEV_CODE))
            active = 1'b0;
        else if (byte_idx == 0)
        begin
            addr[10:8] = rx.ctrl.block;   // block bits are the high address bits
            rd_next    = rx.ctrl.rw;
        end
        else if (byte_idx == 1)
            addr[7:0] = rx.raw;
        else
            mem[addr] = rx.raw;
        sda_low = active;   // ack only while still addressed
    endtask

    always @(negedge sda)
    begin
        if (scl === 1'b1)   // start or repeated start
        begin
            active    = 1'b1;
            reading   = 1'b0;
            rd_next   = 1'b0;
            skip_fall = 1'b1;
            bit_idx   = 0;
            byte_idx  = 0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)   // stop
        begin
            active  = 1'b0;
            reading = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (active && !reading && bit_idx < 8)
            shift = {shift[6:0], sda};
        else if (active && reading && bit_idx == 8 && sda)
        begin
            active  = 1'b0;   // master NACK ends the read
            reading = 1'b0;
        end
    end

    always @(negedge scl)
    begin
        if (!active)
            sda_low = 1'b0;
        else if (skip_fall)
            skip_fall = 1'b0;
        else if (bit_idx < 7)
        begin
            bit_idx = bit_idx + 1;
            if (reading)
                sda_low = !dout[7 - bit_idx];
        end
        else if (bit_idx == 7)
        begin
            bit_idx = 8;
            if (reading)
                sda_low = 1'b0;   // master answers in the ack slot
            else
                take_byte();
        end
        else
        begin
            bit_idx  = 0;
            byte_idx = byte_idx + 1;
            reading  = rd_next;
            if (reading)
            begin
                dout    = mem[addr];
                sda_low = !dout[7];
            end
            else
                sda_low = 1'b0;
        end
    end

endmodule

//--- eeprom_asserts.sv
`timescale 1ns/100ps

module eeprom_asserts import i2c_pkg::*;
(
    input logic     CLK,
    input logic     RESET,
    input i2c_op_t  op,
    input logic     active,
    input logic     cmd_valid,
    input logic     cmd_ready,
    input i2c_cmd_t cmd,
    input logic     op_done,
    input logic     scl_low,
    input logic     sda_low
);

    localparam int COND_CYCLES = 4 * SCL_QUARTER;    // start or stop
    localparam int BYTE_CYCLES = 36 * SCL_QUARTER;   // 8 data bits and ack

    // SDA only moves under a high SCL to form a start or a stop
    assert property (@(posedge CLK) disable iff (RESET)
        (!scl_low && !$past(scl_low) && sda_low != $past(sda_low))
            |-> (op == I2C_START || op == I2C_STOP))
        else $error("sda_low changed while SCL high outside START or STOP");

    // ready stays low for the whole transfer and returns with op_done
    assert property (@(posedge CLK) disable iff (RESET)
        (cmd_valid && cmd_ready && (cmd.op == I2C_START || cmd.op == I2C_STOP))
            |=> !cmd_ready [*COND_CYCLES] ##1 (cmd_ready && op_done))
        else $error("cmd_ready not held low for a whole start or stop");

    assert property (@(posedge CLK) disable iff (RESET)
        (cmd_valid && cmd_ready && (cmd.op == I2C_WRITE || cmd.op == I2C_READ))
            |=> !cmd_ready [*BYTE_CYCLES] ##1 (cmd_ready && op_done))
        else $error("cmd_ready not held low for a whole byte transfer");

    // a finished stop leaves the bus free
    assert property (@(posedge CLK) disable iff (RESET)
        (!active && op == I2C_STOP) |-> (!scl_low && !sda_low))
        else $error("bus lines not released after STOP");

endmodule

bind i2c_bit_engine eeprom_asserts u_asserts (.*);

//--- tb_eeprom.sv
`timescale 1ns/100ps

module tb_eeprom import eeprom_pkg::*; ();

    typedef struct packed {
        logic [7:0]  op;
        logic [10:0] addr;
        logic [7:0]  data;
    } golden_t;

    logic                CLK;
    logic                RESET;
    logic [AXI_AW-1:0]   s_awaddr;
    logic                s_awvalid;
    logic                s_awready;
    logic [AXI_DW-1:0]   s_wdata;
    logic [AXI_DW/8-1:0] s_wstrb;
    logic                s_wvalid;
    logic                s_wready;
    logic [1:0]          s_bresp;
    logic                s_bvalid;
    logic                s_bready;
    logic [AXI_AW-1:0]   s_araddr;
    logic                s_arvalid;
    logic                s_arready;
    logic [AXI_DW-1:0]   s_rdata;
    logic [1:0]          s_rresp;
    logic                s_rvalid;
    logic                s_rready;
    logic                scl_low;
    logic                sda_low;
    logic                model_sda_low;
    logic                nack_all;
    wire                 scl_line;
    wire                 sda_line;

    golden_t golden[$];
    int      errors = 0;
    int      checks = 0;
    int      tests = 0;
    int      failed_tests = 0;
    int      cycles = 0;
    int      cycle_limit = 0;
    int      err_mark;
    logic [31:0] rd;

    pullup (scl_line);
    pullup (sda_line);
    assign scl_line = scl_low ? 1'b0 : 1'bz;
    assign sda_line = sda_low ? 1'b0 : 1'bz;
    assign sda_line = model_sda_low ? 1'b0 : 1'bz;

    eeprom_ctrl_top uut (.*, .sda_in(sda_line));

    eeprom_model u_model (
        .scl      (scl_line),
        .sda      (sda_line),
        .nack_all (nack_all),
        .sda_low  (model_sda_low)
    );

    initial
    begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    always @(posedge CLK)
    begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit)
        begin
            $display("timeout after %0d cycles, a transaction never finished", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("Error: %s is %0h, expected %0h", name, actual, expected);
        end
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
                             input logic [1:0] exp_resp);
        logic aw_hit;
        logic w_hit;
        @(negedge CLK);
        s_awaddr  = addr;
        s_awvalid = 1'b1;
        s_wdata   = data;
        s_wstrb   = 4'hf;
        s_wvalid  = 1'b1;
        s_bready  = 1'b1;
        while (s_awvalid || s_wvalid)
        begin
            aw_hit = s_awready && s_awvalid;   // handshake at the coming edge
            w_hit  = s_wready && s_wvalid;
            @(negedge CLK);
            if (aw_hit)
                s_awvalid = 1'b0;
            if (w_hit)
                s_wvalid = 1'b0;
        end
        while (!s_bvalid)
            @(negedge CLK);
        check_value($sformatf("bresp at %0h", addr), s_bresp, exp_resp);
        @(negedge CLK);
        s_bready = 1'b0;
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [31:0] data,
                            input logic [1:0] exp_resp);
        logic ar_hit;
        @(negedge CLK);
        s_araddr  = addr;
        s_arvalid = 1'b1;
        s_rready  = 1'b1;
        while (s_arvalid)
        begin
            ar_hit = s_arready;
            @(negedge CLK);
            if (ar_hit)
                s_arvalid = 1'b0;
        end
        while (!s_rvalid)
            @(negedge CLK);
        data = s_rdata;
        check_value($sformatf("rresp at %0h", addr), s_rresp, exp_resp);
        @(negedge CLK);
        s_rready = 1'b0;
    endtask

    task automatic wait_done(output logic [31:0] status);
        status = '0;
        while (!status[1])
            read_reg(REG_STATUS, status, RESP_OKAY);
    endtask

    task automatic report_test(input string name, input int mark);
        tests++;
        if (errors == mark)
            $display("%s: pass", name);
        else
        begin
            failed_tests++;
            $display("%s: fail with %0d errors", name, errors - mark);
        end
    endtask

    task automatic load_golden();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [10:0] a;
        logic [7:0]  d;
        fd = $fopen("eeprom_golden.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("cannot open eeprom_golden.txt");
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                if (line.len() > 1 && line.getc(0) != "#")
                begin
                    n = $sscanf(line, "%c %h %h", op, a, d);
                    if (n == 3)
                        golden.push_back('{op: op, addr: a, data: d});
                    else
                    begin
                        errors++;
                        $display("golden line not understood: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_line(input golden_t g);
        logic [31:0] st;
        case (g.op)
            "W", "N":
            begin
                if (g.op == "N")
                begin
                    @(negedge CLK);
                    nack_all = 1'b1;
                end
                write_reg(REG_ADDR, g.addr, RESP_OKAY);
                write_reg(REG_WDATA, g.data, RESP_OKAY);
                write_reg(REG_CTRL, 32'h1, RESP_OKAY);
                wait_done(st);
                check_value("status.nack", st[2], g.op == "N");
                if (g.op == "N")
                begin
                    write_reg(REG_CTRL, 32'h2, RESP_OKAY);
                    wait_done(st);
                    check_value("status.nack", st[2], 1'b1);
                    @(negedge CLK);
                    nack_all = 1'b0;
                end
            end
            "R":
            begin
                write_reg(REG_ADDR, g.addr, RESP_OKAY);
                write_reg(REG_CTRL, 32'h2, RESP_OKAY);
                wait_done(st);
                check_value("status.nack", st[2], 1'b0);
                check_value("status.rdata", st[15:8], g.data);
            end
            "X":
            begin
                write_reg(REG_ADDR, g.addr, RESP_OKAY);
                write_reg(REG_WDATA, g.data, RESP_OKAY);
                write_reg(REG_CTRL, 32'h1, RESP_OKAY);
                write_reg(REG_WDATA, 32'(~g.data), RESP_OKAY);   // lands in memory if it starts
                write_reg(REG_CTRL, 32'h1, RESP_OKAY);
                wait_done(st);
                check_value("status.nack", st[2], 1'b0);
                repeat (8) @(negedge CLK);
                read_reg(REG_STATUS, st, RESP_OKAY);
                check_value("status.busy", st[0], 1'b0);
                check_value("status.done", st[1], 1'b1);
            end
            default:
            begin
                errors++;
                $display("unknown operation %c in the golden file", g.op);
            end
        endcase
    endtask

    initial
    begin
        RESET     = 1'b1;
        s_awaddr  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wstrb   = '0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b0;
        s_araddr  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b0;
        nack_all  = 1'b0;
        load_golden();
        cycle_limit = golden.size() * 250 + 100;
        repeat (8) @(negedge CLK);
        RESET = 1'b0;

        err_mark = errors;
        read_reg(REG_STATUS, rd, RESP_OKAY);
        check_value("status", rd, 32'h0);
        check_value("scl", scl_line, 1'b1);
        check_value("sda", sda_line, 1'b1);
        report_test("after reset", err_mark);

        foreach (golden[i])
        begin
            err_mark = errors;
            run_line(golden[i]);
            report_test($sformatf("golden line %0d %c %h %h", i, golden[i].op,
                                  golden[i].addr, golden[i].data), err_mark);
        end

        // 0x6 lies between WDATA and CTRL, outside the map
        err_mark = errors;
        write_reg(REG_ADDR, 32'h155, RESP_OKAY);
        write_reg(REG_WDATA, 32'h6b, RESP_OKAY);
        write_reg(4'h6, 32'hffff_ffff, RESP_SLVERR);
        read_reg(4'h6, rd, RESP_SLVERR);
        read_reg(REG_ADDR, rd, RESP_OKAY);
        check_value("addr", rd, 32'h155);
        read_reg(REG_WDATA, rd, RESP_OKAY);
        check_value("wdata", rd, 32'h6b);
        report_test("unmapped offset", err_mark);

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- eeprom_golden.txt
# op addr data, hex. W writes data, R reads and expects data, N writes then reads
# with the slave refusing every byte, X writes data then tries a second CTRL write
W 005 3c
W 1a7 c5
W 233 01
W 3fe 80
W 44a 7e
W 5b1 a5
W 612 5a
W 7ff e7
R 005 3c
R 1a7 c5
R 233 01
R 3fe 80
R 44a 7e
R 5b1 a5
R 612 5a
R 7ff e7
R 0c0 ff
N 233 99
R 233 01
X 140 d2
R 140 d2

//--- verilog.f
i2c_pkg.sv
eeprom_pkg.sv
axil_eeprom_regs.sv
eeprom_txn_seq.sv
i2c_bit_engine.sv
eeprom_ctrl_top.sv
eeprom_model.sv
eeprom_asserts.sv
tb_eeprom.sv
